// ==== rtl/regReadPkg.sv ====
// Shared sizes for the register-read stage.
// Operand, tag and packet types for issue, bypass, unmap/wakeup and mispredict.

package regReadPkg;

  parameter int DataWidth         = 32;
  parameter int PhysRegs          = 64;
  parameter int PhysTagWidth      = $clog2(PhysRegs);
  parameter int ArchRegs          = 32;  // registers that hold committed state after reset.
  parameter int Checkpoints       = 4;
  parameter int CheckpointIdWidth = $clog2(Checkpoints);
  parameter int PayloadWidth      = 48;

  typedef logic [PhysTagWidth-1:0] phyTagT;
  typedef logic [DataWidth-1:0]    dataT;

  // Instruction as it leaves the issue queue.
  // The payload holds opcode, immediate, queue indices and PC, which this stage never looks at.
  typedef struct packed {
    logic [Checkpoints-1:0]  branchMask;
    phyTagT                  src1;
    phyTagT                  src2;
    phyTagT                  dest;
    logic [PayloadWidth-1:0] payload;
  } issuePacketT;

  // Result broadcast by a functional unit.
  typedef struct packed {
    phyTagT dest;
    dataT   data;
  } bypassPacketT;

  // Issue packet with both operands attached, sent on to execute.
  typedef struct packed {
    dataT        data2;
    dataT        data1;
    issuePacketT inst;
  } readPacketT;

  // Tag request for the ready table, used for unmap and wakeup alike.
  typedef struct packed {
    logic   valid;
    phyTagT tag;
  } tagReqT;

  // Branch resolution broadcast.
  typedef struct packed {
    logic                         verified;
    logic                         mispredict;
    logic [CheckpointIdWidth-1:0] smtId;  // checkpoint of the resolved branch.
  } mispredictT;

endpackage

// ==== rtl/physRegFile.sv ====
// Physical register file.
// One write port and two combinational read ports per lane.

`timescale 1ns/1ps

module physRegFile
  import regReadPkg::*;
#(
  parameter int NumLanes = 2
) (
  input  logic                clk,
  input  logic                rstN_i,
  input  logic [NumLanes-1:0] wrEn_i,
  input  bypassPacketT        wrPkt_i  [NumLanes],
  input  phyTagT              rdTag_i  [2*NumLanes],
  output dataT                rdData_o [2*NumLanes]
);

  dataT regs [PhysRegs];

  // Each lane writes its own result.
  // Two lanes should never target one tag, but if they do the higher lane is kept.
  always_ff @(posedge clk or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      for (int r = 0; r < PhysRegs; r++)
      begin
        regs[r] <= '0;
      end
    end
    else
    begin
      for (int l = 0; l < NumLanes; l++)
      begin
        if (wrEn_i[l])
        begin
          regs[wrPkt_i[l].dest] <= wrPkt_i[l].data;
        end
      end
    end
  end

  // reads see the array contents only, so a same-cycle write is picked up by the bypass logic.
  always_comb
  begin
    for (int p = 0; p < 2*NumLanes; p++)
    begin
      rdData_o[p] = regs[rdTag_i[p]];
    end
  end

endmodule

// ==== rtl/readyTable.sv ====
// Ready table of the physical registers.
// Reset and exception restore, unmap clears and wakeup sets.

`timescale 1ns/1ps

module readyTable
  import regReadPkg::*;
#(
  parameter int NumLanes = 2
) (
  input  logic                clk,
  input  logic                rstN_i,
  input  logic                exception_i,
  input  tagReqT              unmap_i  [NumLanes],
  input  tagReqT              wakeup_i [NumLanes],
  output logic [PhysRegs-1:0] phyRegRdy_o
);

  // committed registers are ready, free and in-flight ones are not.
  localparam logic [PhysRegs-1:0] ArchRdyMask =
    {{(PhysRegs-ArchRegs){1'b0}}, {ArchRegs{1'b1}}};

  logic [PhysRegs-1:0] rdyQ;
  logic [PhysRegs-1:0] rdyNext;

  always_comb
  begin
    rdyNext = rdyQ;
    for (int l = 0; l < NumLanes; l++)
    begin
      if (unmap_i[l].valid)
      begin
        rdyNext[unmap_i[l].tag] = 1'b0;
      end
    end
    // Wakeups are applied last so a tag that is freed and woken together ends up ready.
    for (int l = 0; l < NumLanes; l++)
    begin
      if (wakeup_i[l].valid)
      begin
        rdyNext[wakeup_i[l].tag] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rstN_i)
  begin
    if (!rstN_i)
      rdyQ <= ArchRdyMask;
    else if (exception_i)
      rdyQ <= ArchRdyMask;  // the map table is rolled back to committed state.
    else
      rdyQ <= rdyNext;
  end

  assign phyRegRdy_o = rdyQ;

endmodule

// ==== rtl/operandBypass.sv ====
// Operand bypass for every source of every lane.
// Tag match against the valid bypass results, lowest lane first, else register file data.

`timescale 1ns/1ps

module operandBypass
  import regReadPkg::*;
#(
  parameter int NumLanes = 2
) (
  input  issuePacketT         issuePkt_i    [NumLanes],
  input  dataT                rfData_i      [2*NumLanes],
  input  bypassPacketT        bypassPkt_i   [NumLanes],
  input  logic [NumLanes-1:0] bypassValid_i,
  output dataT                operand1_o    [NumLanes],
  output dataT                operand2_o    [NumLanes]
);

  // match vectors, one bit per bypass lane.
  logic [NumLanes-1:0] src1Match [NumLanes];
  logic [NumLanes-1:0] src2Match [NumLanes];

  always_comb
  begin
    for (int l = 0; l < NumLanes; l++)
    begin
      for (int b = 0; b < NumLanes; b++)
      begin
        src1Match[l][b] = bypassValid_i[b] && (bypassPkt_i[b].dest == issuePkt_i[l].src1);
        src2Match[l][b] = bypassValid_i[b] && (bypassPkt_i[b].dest == issuePkt_i[l].src2);
      end
    end
  end

  // The scan runs from the highest lane down, so the lowest matching lane is the one that stays.
  // A result being written this cycle is not yet in the array, which is why it must come from here.
  always_comb
  begin
    for (int l = 0; l < NumLanes; l++)
    begin
      operand1_o[l] = rfData_i[2*l];
      operand2_o[l] = rfData_i[2*l+1];
      for (int b = NumLanes - 1; b >= 0; b--)
      begin
        if (src1Match[l][b])
        begin
          operand1_o[l] = bypassPkt_i[b].data;
        end
        if (src2Match[l][b])
        begin
          operand2_o[l] = bypassPkt_i[b].data;
        end
      end
    end
  end

endmodule

// ==== rtl/squashFilter.sv ====
// Mispredict squash of the lane valids.
// Read packet assembly from the issue packet and its two operands.

`timescale 1ns/1ps

module squashFilter
  import regReadPkg::*;
#(
  parameter int NumLanes = 2
) (
  input  issuePacketT         issuePkt_i   [NumLanes],
  input  logic [NumLanes-1:0] issueValid_i,
  input  dataT                operand1_i   [NumLanes],
  input  dataT                operand2_i   [NumLanes],
  input  mispredictT          mispredict_i,
  output readPacketT          readPkt_o    [NumLanes],
  output logic [NumLanes-1:0] readValid_o
);

  logic killEvent;

  // only a verified mispredict kills younger instructions.
  assign killEvent = mispredict_i.verified & mispredict_i.mispredict;

  always_comb
  begin
    for (int l = 0; l < NumLanes; l++)
    begin
      // A lane depends on the branch when its mask bit for that checkpoint is set.
      readValid_o[l] = issueValid_i[l] &
                       ~(killEvent & issuePkt_i[l].branchMask[mispredict_i.smtId]);
      readPkt_o[l].data2 = operand2_i[l];
      readPkt_o[l].data1 = operand1_i[l];
      readPkt_o[l].inst  = issuePkt_i[l];
    end
  end

endmodule

// ==== rtl/regReadStage.sv ====
// Register-read stage top level.
// Register file and ready table, operand bypass, and the mispredict squash on the outputs.

`timescale 1ns/1ps

module regReadStage
  import regReadPkg::*;
#(
  parameter int NumLanes = 2
) (
  input  logic                clk,
  input  logic                rstN_i,

  // issue side.
  input  issuePacketT         issuePkt_i    [NumLanes],
  input  logic [NumLanes-1:0] issueValid_i,

  // results from the functional units.
  input  bypassPacketT        bypassPkt_i   [NumLanes],
  input  logic [NumLanes-1:0] bypassValid_i,

  // ready table requests.
  input  tagReqT              unmap_i       [NumLanes],
  input  tagReqT              wakeup_i      [NumLanes],

  input  mispredictT          mispredict_i,
  input  logic                recover_i,
  input  logic                exception_i,

  output readPacketT          readPkt_o     [NumLanes],
  output logic [NumLanes-1:0] readValid_o,
  output logic [PhysRegs-1:0] phyRegRdy_o
);

  logic [NumLanes-1:0] rfWrEn;
  phyTagT              rfRdTag  [2*NumLanes];
  dataT                rfRdData [2*NumLanes];
  dataT                operand1 [NumLanes];
  dataT                operand2 [NumLanes];

  // results of squashed work must not land in the file while recovery is running.
  assign rfWrEn = bypassValid_i & {NumLanes{~recover_i}};

  // Read ports are paired per lane, src1 on the even port and src2 on the odd one.
  always_comb
  begin
    for (int l = 0; l < NumLanes; l++)
    begin
      rfRdTag[2*l]   = issuePkt_i[l].src1;
      rfRdTag[2*l+1] = issuePkt_i[l].src2;
    end
  end

  physRegFile #(
    .NumLanes (NumLanes)
  ) physRegFile_i (
    .clk      (clk),
    .rstN_i   (rstN_i),
    .wrEn_i   (rfWrEn),
    .wrPkt_i  (bypassPkt_i),
    .rdTag_i  (rfRdTag),
    .rdData_o (rfRdData)
  );

  readyTable #(
    .NumLanes (NumLanes)
  ) readyTable_i (
    .clk         (clk),
    .rstN_i      (rstN_i),
    .exception_i (exception_i),
    .unmap_i     (unmap_i),
    .wakeup_i    (wakeup_i),
    .phyRegRdy_o (phyRegRdy_o)
  );

  operandBypass #(
    .NumLanes (NumLanes)
  ) operandBypass_i (
    .issuePkt_i    (issuePkt_i),
    .rfData_i      (rfRdData),
    .bypassPkt_i   (bypassPkt_i),
    .bypassValid_i (bypassValid_i),
    .operand1_o    (operand1),
    .operand2_o    (operand2)
  );

  squashFilter #(
    .NumLanes (NumLanes)
  ) squashFilter_i (
    .issuePkt_i   (issuePkt_i),
    .issueValid_i (issueValid_i),
    .operand1_i   (operand1),
    .operand2_i   (operand2),
    .mispredict_i (mispredict_i),
    .readPkt_o    (readPkt_o),
    .readValid_o  (readValid_o)
  );

endmodule

// ==== tests/clockGen.sv ====
// Testbench clock and power-on reset.

`timescale 1ns/1ps

module clockGen #(
  parameter int Period      = 20,
  parameter int ResetCycles = 2
) (
  output logic clk_o,
  output logic rstN_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #(Period/2) clk_o = ~clk_o;
    end
  end

  initial
  begin
    rstN_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rstN_o <= 1'b1;  // released on a rising edge, like a synchronized reset.
  end

endmodule

// ==== tests/regReadTb.sv ====
// Directed testbench of the register-read stage.
// Reset state, register file, forwarding, mispredict squash and ready table tests.

`timescale 1ns/1ps

module regReadTb
  import regReadPkg::*;
();

  localparam int NumLanes      = 2;
  localparam int TimeoutCycles = 2000;  // the tests need under a hundred cycles.

  logic clk;
  logic rstN;

  issuePacketT         issuePkt    [NumLanes];
  logic [NumLanes-1:0] issueValid;
  bypassPacketT        bypassPkt   [NumLanes];
  logic [NumLanes-1:0] bypassValid;
  tagReqT              unmap       [NumLanes];
  tagReqT              wakeup      [NumLanes];
  mispredictT          mispredict;
  logic                recover;
  logic                exception;
  readPacketT          readPkt     [NumLanes];
  logic [NumLanes-1:0] readValid;
  logic [PhysRegs-1:0] phyRegRdy;

  dataT                regModel [PhysRegs];  // expected contents of the register file.
  logic [PhysRegs-1:0] rdyModel;
  logic [PhysRegs-1:0] archRdy;
  int                  cycleCount = 0;

  clockGen clockGen_i (
    .clk_o  (clk),
    .rstN_o (rstN)
  );

  regReadStage #(
    .NumLanes (NumLanes)
  ) dut_i (
    .clk           (clk),
    .rstN_i        (rstN),
    .issuePkt_i    (issuePkt),
    .issueValid_i  (issueValid),
    .bypassPkt_i   (bypassPkt),
    .bypassValid_i (bypassValid),
    .unmap_i       (unmap),
    .wakeup_i      (wakeup),
    .mispredict_i  (mispredict),
    .recover_i     (recover),
    .exception_i   (exception),
    .readPkt_o     (readPkt),
    .readValid_o   (readValid),
    .phyRegRdy_o   (phyRegRdy)
  );

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles)
    begin
      $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("=== FAIL ===");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic compareValues(input logic [255:0] actual, input logic [255:0] expected,
                               input string what);
    if (actual !== expected)
    begin
      $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("=== FAIL ===");
      $fatal(1, "stopped at the first error");
    end
  endtask

  // the read packet is the issue packet as driven, with both operands in front.
  task automatic compareLane(input int lane, input dataT data1, input dataT data2);
    readPacketT expPkt;
    expPkt.data1 = data1;
    expPkt.data2 = data2;
    expPkt.inst  = issuePkt[lane];
    compareValues(readPkt[lane], expPkt, $sformatf("read packet of lane %0d", lane));
  endtask

  function automatic issuePacketT makeIssue(input logic [Checkpoints-1:0] mask,
                                            input phyTagT src1, input phyTagT src2);
    issuePacketT p;
    p.branchMask = mask;
    p.src1       = src1;
    p.src2       = src2;
    p.dest       = phyTagT'($urandom);
    p.payload    = PayloadWidth'({$urandom, $urandom});
    return p;
  endfunction

  task automatic idleInputs();
    for (int l = 0; l < NumLanes; l++)
    begin
      issuePkt[l]  <= '0;
      bypassPkt[l] <= '0;
      unmap[l]     <= '0;
      wakeup[l]    <= '0;
    end
    issueValid  <= '0;
    bypassValid <= '0;
    mispredict  <= '0;
    recover     <= 1'b0;
    exception   <= 1'b0;
  endtask

  task automatic resetState();
    for (int r = 0; r < PhysRegs; r++)
    begin
      archRdy[r]  = (r < ArchRegs);
      regModel[r] = '0;
    end
    rdyModel = archRdy;
    @(negedge clk);
    compareValues(phyRegRdy, rdyModel, "ready bits after reset");
    compareValues(readValid, '0, "read valid with idle inputs");
    for (int r = 0; r < PhysRegs; r += 4)
    begin
      @(posedge clk);
      issuePkt[0] <= makeIssue('0, phyTagT'(r), phyTagT'(r + 1));
      issuePkt[1] <= makeIssue('0, phyTagT'(r + 2), phyTagT'(r + 3));
      @(negedge clk);
      compareLane(0, '0, '0);
      compareLane(1, '0, '0);
      compareValues(readValid, '0, "read valid without issue");
    end
  endtask

  task automatic regFileWriteRead();
    phyTagT tagA;
    phyTagT tagB;
    dataT   dataA;
    dataT   dataB;
    for (int i = 0; i < 8; i++)
    begin
      tagA  = phyTagT'(16 + 2*i);
      tagB  = phyTagT'(17 + 2*i);
      dataA = $urandom;
      dataB = $urandom;
      @(posedge clk);
      bypassPkt[0] <= '{dest: tagA, data: dataA};
      bypassPkt[1] <= '{dest: tagB, data: dataB};
      bypassValid  <= 2'b11;
      issuePkt[0]  <= makeIssue('0, '0, '0);
      issuePkt[1]  <= makeIssue('0, '0, '0);
      regModel[tagA] = dataA;
      regModel[tagB] = dataB;
      @(posedge clk);
      bypassValid <= '0;
      issueValid  <= 2'b11;
      issuePkt[0] <= makeIssue('0, tagA, tagB);
      issuePkt[1] <= makeIssue('0, tagB, tagA);
      @(negedge clk);
      compareLane(0, regModel[tagA], regModel[tagB]);
      compareLane(1, regModel[tagB], regModel[tagA]);
      compareValues(readValid, 2'b11, "read valid of issued lanes");
    end
    // a result during recovery must not reach the file.
    @(posedge clk);
    bypassPkt[0] <= '{dest: phyTagT'(16), data: ~regModel[16]};
    bypassValid  <= 2'b01;
    recover      <= 1'b1;
    issueValid   <= '0;
    issuePkt[0]  <= makeIssue('0, '0, '0);
    @(posedge clk);
    bypassValid <= '0;
    recover     <= 1'b0;
    issuePkt[0] <= makeIssue('0, phyTagT'(16), phyTagT'(17));
    @(negedge clk);
    compareLane(0, regModel[16], regModel[17]);
  endtask

  task automatic sameCycleForward();
    phyTagT tagX;
    phyTagT tagY;
    phyTagT tagZ;
    dataT   dataA;
    dataT   dataB;
    tagX  = phyTagT'(40);
    tagY  = phyTagT'(41);
    tagZ  = phyTagT'(20);
    dataA = $urandom;
    dataB = $urandom;
    @(posedge clk);
    bypassPkt[0] <= '{dest: tagX, data: dataA};
    bypassPkt[1] <= '{dest: tagY, data: dataB};
    bypassValid  <= 2'b11;
    recover      <= 1'b1;  // forwarding still works while the file is frozen.
    issueValid   <= 2'b11;
    issuePkt[0]  <= makeIssue('0, tagX, tagY);
    issuePkt[1]  <= makeIssue('0, tagZ, tagX);
    @(negedge clk);
    compareLane(0, dataA, dataB);
    compareLane(1, regModel[tagZ], dataA);
    @(posedge clk);
    bypassPkt[1] <= '{dest: tagX, data: dataB};
    issuePkt[0]  <= makeIssue('0, tagX, tagZ);
    issuePkt[1]  <= makeIssue('0, tagY, tagX);
    @(negedge clk);
    compareLane(0, dataA, regModel[tagZ]);  // lane 0 wins over lane 1.
    compareLane(1, regModel[tagY], dataA);
    @(posedge clk);
    bypassValid <= 2'b10;
    @(negedge clk);
    compareLane(0, dataB, regModel[tagZ]);
    compareLane(1, regModel[tagY], dataB);
    @(posedge clk);
    idleInputs();
  endtask

  task automatic mispredictSquash();
    logic [Checkpoints-1:0]       mask [NumLanes];
    logic [NumLanes-1:0]          valids;
    logic [NumLanes-1:0]          expValid;
    logic [CheckpointIdWidth-1:0] smt;
    logic                         ver;
    logic                         mis;
    for (int i = 0; i < 16; i++)
    begin
      ver     = i[0];
      mis     = i[1];
      smt     = i[3:2];
      mask[0] = Checkpoints'($urandom) | (Checkpoints'(1) << smt);
      mask[1] = Checkpoints'($urandom) & ~(Checkpoints'(1) << smt);
      valids  = (i % 5 == 4) ? NumLanes'($urandom) : 2'b11;
      @(posedge clk);
      issuePkt[0] <= makeIssue(mask[0], phyTagT'(16), phyTagT'(18));
      issuePkt[1] <= makeIssue(mask[1], phyTagT'(21), phyTagT'(23));
      issueValid  <= valids;
      mispredict  <= '{verified: ver, mispredict: mis, smtId: smt};
      @(negedge clk);
      expValid[0] = valids[0] && !(ver && mis);  // lane 0 depends on the resolved branch.
      expValid[1] = valids[1];  // lane 1 never does.
      compareValues(readValid, expValid, "read valid under mispredict");
      compareLane(0, regModel[16], regModel[18]);
      compareLane(1, regModel[21], regModel[23]);
    end
    @(posedge clk);
    idleInputs();
  endtask

  task automatic readyTableUpdates();
    @(posedge clk);
    unmap[0]  <= '{valid: 1'b1, tag: phyTagT'(5)};
    wakeup[1] <= '{valid: 1'b1, tag: phyTagT'(40)};
    @(negedge clk);
    compareValues(phyRegRdy, rdyModel, "ready bits before the update edge");
    rdyModel[5]  = 1'b0;
    rdyModel[40] = 1'b1;
    @(posedge clk);
    unmap[0]  <= '{valid: 1'b1, tag: phyTagT'(10)};
    wakeup[1] <= '{valid: 1'b1, tag: phyTagT'(10)};
    unmap[1]  <= '{valid: 1'b1, tag: phyTagT'(41)};
    wakeup[0] <= '{valid: 1'b1, tag: phyTagT'(41)};
    @(negedge clk);
    compareValues(phyRegRdy, rdyModel, "ready bits after unmap and wakeup");
    rdyModel[10] = 1'b1;
    rdyModel[41] = 1'b1;
    @(posedge clk);
    exception <= 1'b1;
    unmap[0]  <= '{valid: 1'b1, tag: phyTagT'(3)};
    wakeup[0] <= '{valid: 1'b1, tag: phyTagT'(50)};
    unmap[1]  <= '0;
    wakeup[1] <= '0;
    @(negedge clk);
    compareValues(phyRegRdy, rdyModel, "ready bits after colliding requests");
    rdyModel = archRdy;
    @(posedge clk);
    idleInputs();
    @(negedge clk);
    compareValues(phyRegRdy, rdyModel, "ready bits after exception");
  endtask

  initial
  begin
    void'($urandom(32'hd7395838));
    idleInputs();
    wait (rstN === 1'b1);
    resetState();
    regFileWriteRead();
    sameCycleForward();
    mispredictSquash();
    readyTableUpdates();
    @(posedge clk);
    idleInputs();
    @(negedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== regRead.f ====
rtl/regReadPkg.sv
rtl/physRegFile.sv
rtl/readyTable.sv
rtl/operandBypass.sv
rtl/squashFilter.sv
rtl/regReadStage.sv
tests/clockGen.sv
tests/regReadTb.sv
